// File: md_isa_pkg.sv
package md_isa_pkg;

    // encoding: bit 2 is word form, bit 1 is remainder, bit 0 is unsigned.
    typedef enum logic [2:0] {
        OP_DIV   = 3'd0,
        OP_DIVU  = 3'd1,
        OP_REM   = 3'd2,
        OP_REMU  = 3'd3,
        OP_DIVW  = 3'd4,
        OP_DIVUW = 3'd5,
        OP_REMW  = 3'd6,
        OP_REMUW = 3'd7
    } div_op_e;

    function automatic logic op_is_signed(input div_op_e op);
        return op inside {OP_DIV, OP_REM, OP_DIVW, OP_REMW};
    endfunction

    function automatic logic op_is_word(input div_op_e op);
        return op inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
    endfunction

    function automatic logic op_is_rem(input div_op_e op);
        return op inside {OP_REM, OP_REMU, OP_REMW, OP_REMUW};
    endfunction

endpackage

// File: div_ctrl_pkg.sv
package div_ctrl_pkg;

    // iterative core.
    typedef enum logic [1:0] {
        ITER_IDLE = 2'd0,
        ITER_RUN  = 2'd1,
        ITER_DONE = 2'd2
    } div_iter_state_e;

    // issue stage.
    typedef enum logic [1:0] {
        ISS_IDLE = 2'd0,
        ISS_WAIT = 2'd1,  // core busy.
        ISS_RESP = 2'd2   // result held for the requester.
    } div_issue_state_e;

endpackage

// File: div_iter.sv
`timescale 1ns/1ps

module div_iter #(
    parameter int xlen = 64
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            flush,
    input  logic            iter_start,
    input  logic            iter_signed,
    input  logic [xlen-1:0] iter_dividend,
    input  logic [xlen-1:0] iter_divisor,
    output logic            iter_done,
    output logic [xlen-1:0] iter_quotient,
    output logic [xlen-1:0] iter_remainder
);

    localparam int cnt_w = $clog2(xlen);

    div_ctrl_pkg::div_iter_state_e state_q;
    div_ctrl_pkg::div_iter_state_e state_d;

    logic [cnt_w-1:0]  cnt_q;
    logic              last_step;
    logic              load;
    logic              step;

    logic [2*xlen-1:0] rem_q;      // partial remainder and unused dividend bits.
    logic [xlen-1:0]   divisor_q;
    logic [xlen-1:0]   quot_q;
    logic              dividend_neg_q;
    logic              divisor_neg_q;

    logic              dividend_neg;
    logic              divisor_neg;
    logic [xlen-1:0]   dividend_mag;
    logic [xlen-1:0]   divisor_mag;
    logic [xlen:0]     trial;
    logic [xlen+1:0]   diff;
    logic              borrow;

    assign load = (state_q == div_ctrl_pkg::ITER_IDLE) && iter_start;
    assign step = (state_q == div_ctrl_pkg::ITER_RUN);
    assign last_step = (cnt_q == cnt_w'(xlen - 1));

    // magnitudes of the operands, signs only count for signed forms.
    assign dividend_neg = iter_signed & iter_dividend[xlen-1];
    assign divisor_neg  = iter_signed & iter_divisor[xlen-1];
    assign dividend_mag = dividend_neg ? ~iter_dividend + 1'b1 : iter_dividend;
    assign divisor_mag  = divisor_neg ? ~iter_divisor + 1'b1 : iter_divisor;

    // trial subtraction on the upper remainder shifted by one.
    assign trial  = rem_q[2*xlen-1:xlen-1];
    assign diff   = {1'b0, trial} - {2'b00, divisor_q};
    assign borrow = diff[xlen+1];

    always_comb begin
        state_d = state_q;
        case (state_q)
            div_ctrl_pkg::ITER_IDLE: begin
                if (iter_start) begin
                    state_d = div_ctrl_pkg::ITER_RUN;
                end
            end
            div_ctrl_pkg::ITER_RUN: begin
                if (last_step) begin
                    state_d = div_ctrl_pkg::ITER_DONE;
                end
            end
            div_ctrl_pkg::ITER_DONE: begin
                state_d = div_ctrl_pkg::ITER_IDLE;
            end
            default: begin
                state_d = div_ctrl_pkg::ITER_IDLE;
            end
        endcase
        if (flush) begin
            state_d = div_ctrl_pkg::ITER_IDLE;  // drop the operation in flight.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= div_ctrl_pkg::ITER_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (step) begin
                cnt_q <= cnt_q + 1'b1;
            end else begin
                cnt_q <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rem_q          <= {{xlen{1'b0}}, dividend_mag};
            divisor_q      <= divisor_mag;
            quot_q         <= '0;
            dividend_neg_q <= dividend_neg;
            divisor_neg_q  <= divisor_neg;
        end else if (step) begin
            if (borrow) begin
                rem_q <= {rem_q[2*xlen-2:0], 1'b0};  // restore.
            end else begin
                rem_q <= {diff[xlen-1:0], rem_q[xlen-2:0], 1'b0};
            end
            quot_q <= {quot_q[xlen-2:0], ~borrow};
        end
    end

    assign iter_done = (state_q == div_ctrl_pkg::ITER_DONE);

    // sign correction, remainder follows the dividend.
    assign iter_quotient  = (dividend_neg_q ^ divisor_neg_q) ? ~quot_q + 1'b1 : quot_q;
    assign iter_remainder = dividend_neg_q ? ~rem_q[2*xlen-1:xlen] + 1'b1
                                           : rem_q[2*xlen-1:xlen];

    // the issue stage only starts the core once the previous run has ended.
    a_start_in_idle: assert property (@(posedge clk) disable iff (!arst_n)
        iter_start |-> state_q == div_ctrl_pkg::ITER_IDLE);

    // an unflushed run takes xlen steps, then a single done cycle.
    a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        load && !flush ##1 (!flush) [*xlen] |=> iter_done ##1 !iter_done);

endmodule

// File: div_issue.sv
`timescale 1ns/1ps

module div_issue #(
    parameter int xlen = 64
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                req_valid,
    input  md_isa_pkg::div_op_e req_op,
    input  logic [xlen-1:0]     req_a,
    input  logic [xlen-1:0]     req_b,
    output logic                req_ready,
    input  logic                rsp_ready,
    output logic                rsp_valid,
    output logic [xlen-1:0]     rsp_data,
    output logic                iter_start,
    output logic                iter_signed,
    output logic [xlen-1:0]     iter_dividend,
    output logic [xlen-1:0]     iter_divisor,
    input  logic                iter_done,
    input  logic [xlen-1:0]     iter_quotient,
    input  logic [xlen-1:0]     iter_remainder
);

    div_ctrl_pkg::div_issue_state_e state_q;
    div_ctrl_pkg::div_issue_state_e state_d;

    md_isa_pkg::div_op_e op_q;
    logic                start_q;
    logic                signed_q;
    logic [xlen-1:0]     dividend_q;
    logic [xlen-1:0]     divisor_q;
    logic [xlen-1:0]     rsp_data_q;

    logic                accept;
    logic                req_signed;
    logic                req_word;
    logic [xlen-1:0]     prep_a;
    logic [xlen-1:0]     prep_b;
    logic                div_by_zero;
    logic [xlen-1:0]     zero_result;
    logic [xlen-1:0]     core_result;

    // low word extended to xlen by signedness.
    function automatic logic [xlen-1:0] ext32(input logic [31:0] v, input logic sgn);
        if (sgn) begin
            return xlen'($signed(v));
        end
        return xlen'(v);
    endfunction

    function automatic logic [xlen-1:0] word_fix(input logic [xlen-1:0] v, input logic word);
        return word ? ext32(v[31:0], 1'b1) : v;
    endfunction

    assign accept     = req_valid && req_ready;
    assign req_signed = md_isa_pkg::op_is_signed(req_op);
    assign req_word   = md_isa_pkg::op_is_word(req_op);

    // word forms ignore the upper operand bits.
    assign prep_a = req_word ? ext32(req_a[31:0], req_signed) : req_a;
    assign prep_b = req_word ? ext32(req_b[31:0], req_signed) : req_b;

    assign div_by_zero = (prep_b == '0);
    assign zero_result = md_isa_pkg::op_is_rem(req_op) ? prep_a : '1;
    assign core_result = md_isa_pkg::op_is_rem(op_q) ? iter_remainder : iter_quotient;

    always_comb begin
        state_d = state_q;
        case (state_q)
            div_ctrl_pkg::ISS_IDLE: begin
                if (accept) begin
                    state_d = div_by_zero ? div_ctrl_pkg::ISS_RESP : div_ctrl_pkg::ISS_WAIT;
                end
            end
            div_ctrl_pkg::ISS_WAIT: begin
                if (iter_done) begin
                    state_d = div_ctrl_pkg::ISS_RESP;
                end
            end
            div_ctrl_pkg::ISS_RESP: begin
                if (rsp_ready) begin
                    state_d = div_ctrl_pkg::ISS_IDLE;
                end
            end
            default: begin
                state_d = div_ctrl_pkg::ISS_IDLE;
            end
        endcase
        if (flush) begin
            state_d = div_ctrl_pkg::ISS_IDLE;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= div_ctrl_pkg::ISS_IDLE;
            start_q <= 1'b0;
        end else begin
            state_q <= state_d;
            start_q <= accept && !div_by_zero && !flush;  // one-cycle pulse.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q       <= req_op;
            signed_q   <= req_signed;
            dividend_q <= prep_a;
            divisor_q  <= prep_b;
            if (div_by_zero) begin
                rsp_data_q <= word_fix(zero_result, req_word);
            end
        end else if (state_q == div_ctrl_pkg::ISS_WAIT && iter_done) begin
            rsp_data_q <= word_fix(core_result, md_isa_pkg::op_is_word(op_q));
        end
    end

    assign req_ready     = (state_q == div_ctrl_pkg::ISS_IDLE);
    assign rsp_valid     = (state_q == div_ctrl_pkg::ISS_RESP);
    assign rsp_data      = rsp_data_q;
    assign iter_start    = start_q;
    assign iter_signed   = signed_q;
    assign iter_dividend = dividend_q;
    assign iter_divisor  = divisor_q;

    a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> $stable(rsp_data));

endmodule

// File: div_top.sv
`timescale 1ns/1ps

module div_top #(
    parameter int xlen = 64
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                req_valid,
    input  md_isa_pkg::div_op_e req_op,
    input  logic [xlen-1:0]     req_a,
    input  logic [xlen-1:0]     req_b,
    output logic                req_ready,
    output logic                rsp_valid,
    output logic [xlen-1:0]     rsp_data,
    input  logic                rsp_ready
);

    logic            iter_start;
    logic            iter_signed;
    logic [xlen-1:0] iter_dividend;
    logic [xlen-1:0] iter_divisor;
    logic            iter_done;
    logic [xlen-1:0] iter_quotient;
    logic [xlen-1:0] iter_remainder;

    div_issue #(
        .xlen(xlen)
    ) u_issue (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .req_valid     (req_valid),
        .req_op        (req_op),
        .req_a         (req_a),
        .req_b         (req_b),
        .req_ready     (req_ready),
        .rsp_ready     (rsp_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .iter_start    (iter_start),
        .iter_signed   (iter_signed),
        .iter_dividend (iter_dividend),
        .iter_divisor  (iter_divisor),
        .iter_done     (iter_done),
        .iter_quotient (iter_quotient),
        .iter_remainder(iter_remainder)
    );

    div_iter #(
        .xlen(xlen)
    ) u_iter (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .iter_start    (iter_start),
        .iter_signed   (iter_signed),
        .iter_dividend (iter_dividend),
        .iter_divisor  (iter_divisor),
        .iter_done     (iter_done),
        .iter_quotient (iter_quotient),
        .iter_remainder(iter_remainder)
    );

endmodule

// File: tb_div_top.sv
`timescale 1ns/1ps

module tb_div_top;

    localparam int xlen = 64;

    logic                clk;
    logic                arst_n;
    logic                flush;
    logic                req_valid;
    md_isa_pkg::div_op_e req_op;
    logic [xlen-1:0]     req_a;
    logic [xlen-1:0]     req_b;
    logic                req_ready;
    logic                rsp_valid;
    logic [xlen-1:0]     rsp_data;
    logic                rsp_ready;

    logic [xlen-1:0]     exp_data;
    string               test_name;
    logic                pending;  // accepted operation still owes a response.

    div_top #(.xlen(xlen)) u_dut (
        .clk(clk), .arst_n(arst_n), .flush(flush),
        .req_valid(req_valid), .req_op(req_op), .req_a(req_a), .req_b(req_b),
        .req_ready(req_ready), .rsp_valid(rsp_valid), .rsp_data(rsp_data),
        .rsp_ready(rsp_ready)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // RISC-V divide rules, word forms work on the low 32 bits.
    function automatic logic [63:0] ref_result(input md_isa_pkg::div_op_e op,
                                               input logic [63:0] a, input logic [63:0] b);
        logic        sgn;
        logic [31:0] q32;
        logic [31:0] r32;
        logic [63:0] q;
        logic [63:0] r;
        sgn = md_isa_pkg::op_is_signed(op);
        if (md_isa_pkg::op_is_word(op)) begin
            if (b[31:0] == 32'h0) begin
                q32 = '1;
                r32 = a[31:0];
            end else if (sgn && a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff) begin
                q32 = a[31:0];
                r32 = '0;
            end else if (sgn) begin
                q32 = $signed(a[31:0]) / $signed(b[31:0]);
                r32 = $signed(a[31:0]) % $signed(b[31:0]);
            end else begin
                q32 = a[31:0] / b[31:0];
                r32 = a[31:0] % b[31:0];
            end
            q = {{32{q32[31]}}, q32};
            r = {{32{r32[31]}}, r32};
        end else if (b == 64'h0) begin
            q = '1;
            r = a;
        end else if (sgn && a == {1'b1, 63'h0} && b == '1) begin
            q = a;  // signed overflow.
            r = '0;
        end else if (sgn) begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return md_isa_pkg::op_is_rem(op) ? r : q;
    endfunction

    function automatic logic divisor_is_zero(input md_isa_pkg::div_op_e op, input logic [63:0] b);
        return md_isa_pkg::op_is_word(op) ? (b[31:0] == 32'h0) : (b == 64'h0);
    endfunction

    // corners, small signed values and full random words.
    function automatic logic [63:0] pick_operand();
        int small_val;
        small_val = $urandom_range(0, 2000);
        small_val = small_val - 1000;
        case ($urandom_range(0, 5))
            0: return {1'b1, 63'h0};
            1: return '1;
            2: return {$urandom, 32'h8000_0000};
            3: return {{32{small_val[31]}}, small_val};
            default: return {$urandom, $urandom};
        endcase
    endfunction

    task automatic send_req(input md_isa_pkg::div_op_e op, input logic [63:0] a,
                            input logic [63:0] b, input string name);
        int   cnt;
        logic taken;
        test_name = name;
        exp_data  = ref_result(op, a, b);
        req_op    = op;
        req_a     = a;
        req_b     = b;
        req_valid = 1'b1;
        cnt       = 0;
        taken     = 1'b0;
        while (!taken) begin
            taken = req_ready;  // registered, so this is what the next edge sees.
            @(posedge clk);
            #1;
            cnt++;
            if (!taken && cnt >= 200) begin
                abort_run("request was not accepted within 200 cycles");
            end
        end
        req_valid = 1'b0;
    endtask

    task automatic collect_rsp(input int stall);
        int cnt;
        cnt = 0;
        while (!rsp_valid) begin
            @(posedge clk);
            #1;
            cnt++;
            if (cnt >= 200) begin
                abort_run("no response appeared within 200 cycles");
            end
        end
        for (int k = 0; k < stall; k++) begin
            @(posedge clk);
            #1;
        end
        rsp_ready = 1'b1;
        @(posedge clk);
        #1;
        rsp_ready = 1'b0;
    endtask

    task automatic run_op(input md_isa_pkg::div_op_e op, input logic [63:0] a,
                          input logic [63:0] b, input string name, input int stall);
        send_req(op, a, b, name);
        collect_rsp(stall);
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
        end else if (flush) begin
            pending <= 1'b0;
        end else if (req_valid && req_ready) begin
            pending <= 1'b1;
        end else if (rsp_valid && rsp_ready) begin
            pending <= 1'b0;
        end
    end

    a_reset_state: assert property (@(posedge clk) $rose(arst_n) |-> req_ready && !rsp_valid)
        else abort_run("req_ready low or rsp_valid high after reset");

    a_rsp_data: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && rsp_ready |-> rsp_data == exp_data)
        else abort_run($sformatf("[ERROR] %s: expected %h, actual %h",
                                 test_name, exp_data, $sampled(rsp_data)));

    a_zero_latency: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && req_ready && !flush && divisor_is_zero(req_op, req_b) |-> ##[1:2] rsp_valid)
        else abort_run("divide-by-zero response did not appear within 2 cycles");

    a_rsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready && !flush |=> rsp_valid && $stable(rsp_data))
        else abort_run("response changed or vanished under back-pressure");

    a_busy: assert property (@(posedge clk) disable iff (!arst_n) rsp_valid |-> !req_ready)
        else abort_run("req_ready was high while a response was pending");

    a_flush: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !rsp_valid && req_ready && u_dut.u_iter.state_q == div_ctrl_pkg::ITER_IDLE)
        else abort_run("unit did not return to idle the cycle after flush");

    a_no_stale: assert property (@(posedge clk) disable iff (!arst_n) rsp_valid |-> pending)
        else abort_run("a response appeared with no operation outstanding");

    initial begin
        md_isa_pkg::div_op_e op;
        logic [63:0]         b;
        clk       = 1'b0;
        arst_n    = 1'b0;
        flush     = 1'b0;
        req_valid = 1'b0;
        req_op    = md_isa_pkg::OP_DIV;
        req_a     = '0;
        req_b     = '0;
        rsp_ready = 1'b0;
        exp_data  = '0;
        test_name = "reset";
        void'($urandom(4));
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(posedge clk);
        #1;

        run_op(md_isa_pkg::OP_DIV, {1'b1, 63'h0}, '1, "div_overflow", 0);
        run_op(md_isa_pkg::OP_REM, {1'b1, 63'h0}, '1, "rem_overflow", 0);
        run_op(md_isa_pkg::OP_DIV, -64'sd7, 64'd2, "div_negative", 0);
        run_op(md_isa_pkg::OP_REM, -64'sd7, 64'd2, "rem_negative", 0);
        run_op(md_isa_pkg::OP_DIVU, '1, 64'd3, "divu_large", 0);
        for (int i = 0; i < 40; i++) begin
            op = md_isa_pkg::div_op_e'($urandom_range(0, 3));
            run_op(op, pick_operand(), pick_operand(), "random_full", 0);
        end

        // upper divisor bits of word forms must not hide the zero.
        for (int i = 0; i < 8; i++) begin
            op = md_isa_pkg::div_op_e'(i);
            b  = md_isa_pkg::op_is_word(op) ? {$urandom | 32'h1, 32'h0} : 64'h0;
            run_op(op, pick_operand(), b, "divide_by_zero", 0);
        end

        run_op(md_isa_pkg::OP_DIVW, {32'hdead_beef, 32'h8000_0000}, {32'h1234, 32'hffff_ffff},
               "divw_overflow", 0);
        for (int i = 0; i < 30; i++) begin
            op = md_isa_pkg::div_op_e'($urandom_range(4, 7));
            run_op(op, pick_operand(), pick_operand(), "random_word", 0);
        end

        for (int i = 0; i < 20; i++) begin
            op = md_isa_pkg::div_op_e'($urandom_range(0, 7));
            run_op(op, pick_operand(), pick_operand(), "back_pressure", $urandom_range(1, 6));
        end

        // first flush hits the running core, second a held response.
        for (int i = 0; i < 2; i++) begin
            send_req(md_isa_pkg::OP_DIV, pick_operand(), {$urandom, $urandom} | 64'h1, "flushed");
            repeat ((i == 0) ? 10 : 75) @(posedge clk);
            #1;
            flush = 1'b1;
            @(posedge clk);
            #1;
            flush     = 1'b0;
            rsp_ready = 1'b1;
            repeat (80) @(posedge clk);
            #1;
            rsp_ready = 1'b0;
            run_op(md_isa_pkg::OP_REM, pick_operand(), pick_operand(), "after_flush", 0);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: vlog.f
md_isa_pkg.sv
div_ctrl_pkg.sv
div_iter.sv
div_issue.sv
div_top.sv
tb_div_top.sv

// File: Bender.yml
package:
  name: div_unit

sources:
  - md_isa_pkg.sv
  - div_ctrl_pkg.sv
  - div_iter.sv
  - div_issue.sv
  - div_top.sv
  - target: simulation
    files:
      - tb_div_top.sv
